// ==== common/host_ctrl_pkg.sv ====
// Host control package with bus widths, LLC register map, slave states and response codes
package host_ctrl_pkg;

  // AXI4-Lite configuration bus
  localparam int unsigned AXIL_AW = 32;
  localparam int unsigned AXIL_DW = 32;
  localparam int unsigned AXIL_SW = AXIL_DW / 8;

  // Word index from address bits 7:2
  localparam int unsigned REG_IDX_W = 6;

  // Event counters
  localparam int unsigned NUM_CNT = 5;
  localparam int unsigned CNT_W   = 32;

  localparam int unsigned CNT_RD_HIT  = 0;
  localparam int unsigned CNT_RD_MISS = 1;
  localparam int unsigned CNT_WR_HIT  = 2;
  localparam int unsigned CNT_WR_MISS = 3;
  localparam int unsigned CNT_DMA     = 4;

  // Response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Read data returned on an unmapped access
  localparam logic [AXIL_DW-1:0] ERR_RDATA = 32'hdeadf000;

  // Register map by word index
  typedef enum logic [REG_IDX_W-1:0] {
    REG_CACHE_START = 6'h00,
    REG_CACHE_END   = 6'h01,
    REG_SPM_START   = 6'h02,
    REG_RD_HIT      = 6'h04,
    REG_RD_MISS     = 6'h05,
    REG_WR_HIT      = 6'h06,
    REG_WR_MISS     = 6'h07,
    REG_DMA_EVT     = 6'h08
  } llc_reg_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRESP = 2'd1,
    ST_RRESP = 2'd2
  } axil_state_e;

endpackage

// ==== llc_cfg/llc_cfg_axil_slave.sv ====
// AXI4-Lite slave for the LLC configuration port, one transaction at a time
`timescale 1ns/1ps

module llc_cfg_axil_slave (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Write address and data
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  logic [host_ctrl_pkg::AXIL_AW-1:0]   s_axil_awaddr_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  input  logic [host_ctrl_pkg::AXIL_DW-1:0]   s_axil_wdata_i,
  input  logic [host_ctrl_pkg::AXIL_SW-1:0]   s_axil_wstrb_i,
  // Write response
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  output logic [1:0]                          s_axil_bresp_o,
  // Read address
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  input  logic [host_ctrl_pkg::AXIL_AW-1:0]   s_axil_araddr_i,
  // Read data
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  // Register file side
  output logic                                reg_we_o,
  output logic                                reg_re_o,
  output logic [host_ctrl_pkg::REG_IDX_W-1:0] reg_idx_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   reg_wdata_o,
  output logic [host_ctrl_pkg::AXIL_SW-1:0]   reg_wstrb_o,
  input  logic [host_ctrl_pkg::AXIL_DW-1:0]   reg_rdata_i,
  input  logic                                reg_err_i
);

  host_ctrl_pkg::axil_state_e        state_q;
  host_ctrl_pkg::axil_state_e        state_d;
  logic                              idle;
  logic                              wr_pending;
  logic                              wr_hs;
  logic                              rd_hs;
  logic [1:0]                        bresp_q;
  logic [1:0]                        rresp_q;
  logic [host_ctrl_pkg::AXIL_DW-1:0] rdata_q;

  assign idle       = (state_q == host_ctrl_pkg::ST_IDLE);
  assign wr_pending = s_axil_awvalid_i && s_axil_wvalid_i;

  // Write wins over a read offered in the same cycle
  assign wr_hs = idle && wr_pending;
  assign rd_hs = idle && !wr_pending && s_axil_arvalid_i;

  assign s_axil_awready_o = wr_hs;
  assign s_axil_wready_o  = wr_hs;
  assign s_axil_arready_o = idle && !wr_pending;

  // Single-cycle register access
  assign reg_we_o    = wr_hs;
  assign reg_re_o    = rd_hs;
  assign reg_idx_o   = wr_hs ? s_axil_awaddr_i[host_ctrl_pkg::REG_IDX_W+1:2]
                             : s_axil_araddr_i[host_ctrl_pkg::REG_IDX_W+1:2];
  assign reg_wdata_o = s_axil_wdata_i;
  assign reg_wstrb_o = s_axil_wstrb_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      host_ctrl_pkg::ST_IDLE: begin
        if (wr_hs) begin
          state_d = host_ctrl_pkg::ST_WRESP;
        end else if (rd_hs) begin
          state_d = host_ctrl_pkg::ST_RRESP;
        end
      end
      host_ctrl_pkg::ST_WRESP: begin
        if (s_axil_bready_i) begin
          state_d = host_ctrl_pkg::ST_IDLE;
        end
      end
      host_ctrl_pkg::ST_RRESP: begin
        if (s_axil_rready_i) begin
          state_d = host_ctrl_pkg::ST_IDLE;
        end
      end
      default: state_d = host_ctrl_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= host_ctrl_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Responses captured at the handshake, held until accepted
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      bresp_q <= reg_err_i ? host_ctrl_pkg::RESP_SLVERR : host_ctrl_pkg::RESP_OKAY;
    end
    if (rd_hs) begin
      rresp_q <= reg_err_i ? host_ctrl_pkg::RESP_SLVERR : host_ctrl_pkg::RESP_OKAY;
      rdata_q <= reg_err_i ? host_ctrl_pkg::ERR_RDATA : reg_rdata_i;
    end
  end

  assign s_axil_bvalid_o = (state_q == host_ctrl_pkg::ST_WRESP);
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = (state_q == host_ctrl_pkg::ST_RRESP);
  assign s_axil_rresp_o  = rresp_q;
  assign s_axil_rdata_o  = rdata_q;

endmodule

// ==== llc_cfg/llc_cfg_regfile.sv ====
// LLC configuration registers with address windows, counter readback and clear strobes
`timescale 1ns/1ps

module llc_cfg_regfile (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                reg_we_i,
  input  logic                                reg_re_i,
  input  logic [host_ctrl_pkg::REG_IDX_W-1:0] reg_idx_i,
  input  logic [host_ctrl_pkg::AXIL_DW-1:0]   reg_wdata_i,
  input  logic [host_ctrl_pkg::AXIL_SW-1:0]   reg_wstrb_i,
  input  logic [host_ctrl_pkg::NUM_CNT-1:0][host_ctrl_pkg::CNT_W-1:0] cnt_i,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   reg_rdata_o,
  output logic                                reg_err_o,
  output logic [host_ctrl_pkg::NUM_CNT-1:0]   cnt_clr_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_cache_addr_start_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_cache_addr_end_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_spm_addr_start_o
);

  // Window registers: 0 cache start, 1 cache end, 2 scratchpad start
  logic [2:0][host_ctrl_pkg::AXIL_DW-1:0] win_q;
  logic [2:0]                             win_we;
  logic [host_ctrl_pkg::AXIL_DW-1:0]      rdata;

  always_comb begin
    rdata     = '0;
    reg_err_o = 1'b0;
    win_we    = '0;
    cnt_clr_o = '0;
    case (host_ctrl_pkg::llc_reg_e'(reg_idx_i))
      host_ctrl_pkg::REG_CACHE_START: begin
        rdata     = win_q[0];
        win_we[0] = reg_we_i;
      end
      host_ctrl_pkg::REG_CACHE_END: begin
        rdata     = win_q[1];
        win_we[1] = reg_we_i;
      end
      host_ctrl_pkg::REG_SPM_START: begin
        rdata     = win_q[2];
        win_we[2] = reg_we_i;
      end
      // Counter registers clear on any write
      host_ctrl_pkg::REG_RD_HIT: begin
        rdata                                = cnt_i[host_ctrl_pkg::CNT_RD_HIT];
        cnt_clr_o[host_ctrl_pkg::CNT_RD_HIT] = reg_we_i;
      end
      host_ctrl_pkg::REG_RD_MISS: begin
        rdata                                 = cnt_i[host_ctrl_pkg::CNT_RD_MISS];
        cnt_clr_o[host_ctrl_pkg::CNT_RD_MISS] = reg_we_i;
      end
      host_ctrl_pkg::REG_WR_HIT: begin
        rdata                                = cnt_i[host_ctrl_pkg::CNT_WR_HIT];
        cnt_clr_o[host_ctrl_pkg::CNT_WR_HIT] = reg_we_i;
      end
      host_ctrl_pkg::REG_WR_MISS: begin
        rdata                                 = cnt_i[host_ctrl_pkg::CNT_WR_MISS];
        cnt_clr_o[host_ctrl_pkg::CNT_WR_MISS] = reg_we_i;
      end
      host_ctrl_pkg::REG_DMA_EVT: begin
        rdata                             = cnt_i[host_ctrl_pkg::CNT_DMA];
        cnt_clr_o[host_ctrl_pkg::CNT_DMA] = reg_we_i;
      end
      default: reg_err_o = reg_we_i || reg_re_i;
    endcase
  end

  assign reg_rdata_o = reg_re_i ? rdata : '0;

  // Byte-strobed window update
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      win_q <= '0;
    end else begin
      for (int w = 0; w < 3; w++) begin
        for (int b = 0; b < host_ctrl_pkg::AXIL_SW; b++) begin
          if (win_we[w] && reg_wstrb_i[b]) begin
            win_q[w][8*b +: 8] <= reg_wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  assign llc_cache_addr_start_o = win_q[0];
  assign llc_cache_addr_end_o   = win_q[1];
  assign llc_spm_addr_start_o   = win_q[2];

endmodule

// ==== verilog/llc_event_counters.sv ====
// Wrapping event counters for LLC hit and miss events and cluster DMA events
`timescale 1ns/1ps

module llc_event_counters (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [host_ctrl_pkg::NUM_CNT-1:0]   evt_i,
  input  logic [host_ctrl_pkg::NUM_CNT-1:0]   cnt_clr_i,
  output logic [host_ctrl_pkg::NUM_CNT-1:0][host_ctrl_pkg::CNT_W-1:0] cnt_o
);

  logic [host_ctrl_pkg::NUM_CNT-1:0][host_ctrl_pkg::CNT_W-1:0] cnt_q;
  logic [host_ctrl_pkg::NUM_CNT-1:0][host_ctrl_pkg::CNT_W-1:0] cnt_d;

  always_comb begin
    cnt_d = cnt_q;
    for (int i = 0; i < host_ctrl_pkg::NUM_CNT; i++) begin
      // Clear beats a coincident event
      if (cnt_clr_i[i]) begin
        cnt_d[i] = '0;
      end else if (evt_i[i]) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_o = cnt_q;

endmodule

// ==== verilog/dma_evt_rx.sv ====
// Receiver for the toggle-encoded cluster DMA event with acknowledge and event pulse
`timescale 1ns/1ps

module dma_evt_rx (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ack_o,
  output logic evt_pulse_o
);

  // Stages 0 and 1 synchronize, stage 2 detects the edge
  logic [2:0] sync_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[1:0], valid_i};
    end
  end

  // Acknowledge mirrors the synchronized toggle
  assign ack_o = sync_q[1];

  assign evt_pulse_o = sync_q[1] ^ sync_q[2];

endmodule

// ==== verilog/host_ctrl_top.sv ====
// Host control top level joining the LLC config slave, register file, counters and DMA receiver
`timescale 1ns/1ps

module host_ctrl_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // LLC configuration port
  input  logic                                s_axil_awvalid_i,
  output logic                                s_axil_awready_o,
  input  logic [host_ctrl_pkg::AXIL_AW-1:0]   s_axil_awaddr_i,
  input  logic                                s_axil_wvalid_i,
  output logic                                s_axil_wready_o,
  input  logic [host_ctrl_pkg::AXIL_DW-1:0]   s_axil_wdata_i,
  input  logic [host_ctrl_pkg::AXIL_SW-1:0]   s_axil_wstrb_i,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_bready_i,
  output logic [1:0]                          s_axil_bresp_o,
  input  logic                                s_axil_arvalid_i,
  output logic                                s_axil_arready_o,
  input  logic [host_ctrl_pkg::AXIL_AW-1:0]   s_axil_araddr_i,
  output logic                                s_axil_rvalid_o,
  input  logic                                s_axil_rready_i,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   s_axil_rdata_o,
  output logic [1:0]                          s_axil_rresp_o,
  // LLC events
  input  logic                                llc_read_hit_i,
  input  logic                                llc_read_miss_i,
  input  logic                                llc_write_hit_i,
  input  logic                                llc_write_miss_i,
  // Cluster DMA event
  input  logic                                dma_pe_evt_valid_i,
  output logic                                dma_pe_evt_ack_o,
  // Address windows
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_cache_addr_start_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_cache_addr_end_o,
  output logic [host_ctrl_pkg::AXIL_DW-1:0]   llc_spm_addr_start_o
);

  logic                                                   reg_we;
  logic                                                   reg_re;
  logic [host_ctrl_pkg::REG_IDX_W-1:0]                    reg_idx;
  logic [host_ctrl_pkg::AXIL_DW-1:0]                      reg_wdata;
  logic [host_ctrl_pkg::AXIL_SW-1:0]                      reg_wstrb;
  logic [host_ctrl_pkg::AXIL_DW-1:0]                      reg_rdata;
  logic                                                   reg_err;
  logic [host_ctrl_pkg::NUM_CNT-1:0]                      cnt_clr;
  logic [host_ctrl_pkg::NUM_CNT-1:0][host_ctrl_pkg::CNT_W-1:0] cnt;
  logic                                                   dma_evt_pulse;

  llc_cfg_axil_slave i_axil_slave (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .s_axil_awvalid_i ( s_axil_awvalid_i ),
    .s_axil_awready_o ( s_axil_awready_o ),
    .s_axil_awaddr_i  ( s_axil_awaddr_i  ),
    .s_axil_wvalid_i  ( s_axil_wvalid_i  ),
    .s_axil_wready_o  ( s_axil_wready_o  ),
    .s_axil_wdata_i   ( s_axil_wdata_i   ),
    .s_axil_wstrb_i   ( s_axil_wstrb_i   ),
    .s_axil_bvalid_o  ( s_axil_bvalid_o  ),
    .s_axil_bready_i  ( s_axil_bready_i  ),
    .s_axil_bresp_o   ( s_axil_bresp_o   ),
    .s_axil_arvalid_i ( s_axil_arvalid_i ),
    .s_axil_arready_o ( s_axil_arready_o ),
    .s_axil_araddr_i  ( s_axil_araddr_i  ),
    .s_axil_rvalid_o  ( s_axil_rvalid_o  ),
    .s_axil_rready_i  ( s_axil_rready_i  ),
    .s_axil_rdata_o   ( s_axil_rdata_o   ),
    .s_axil_rresp_o   ( s_axil_rresp_o   ),
    .reg_we_o         ( reg_we           ),
    .reg_re_o         ( reg_re           ),
    .reg_idx_o        ( reg_idx          ),
    .reg_wdata_o      ( reg_wdata        ),
    .reg_wstrb_o      ( reg_wstrb        ),
    .reg_rdata_i      ( reg_rdata        ),
    .reg_err_i        ( reg_err          )
  );

  llc_cfg_regfile i_regfile (
    .clk_i                  ( clk_i                  ),
    .rst_i                  ( rst_i                  ),
    .reg_we_i               ( reg_we                 ),
    .reg_re_i               ( reg_re                 ),
    .reg_idx_i              ( reg_idx                ),
    .reg_wdata_i            ( reg_wdata              ),
    .reg_wstrb_i            ( reg_wstrb              ),
    .cnt_i                  ( cnt                    ),
    .reg_rdata_o            ( reg_rdata              ),
    .reg_err_o              ( reg_err                ),
    .cnt_clr_o              ( cnt_clr                ),
    .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
    .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
    .llc_spm_addr_start_o   ( llc_spm_addr_start_o   )
  );

  // Event order follows the CNT_* indices, DMA on top
  llc_event_counters i_counters (
    .clk_i     ( clk_i                                                        ),
    .rst_i     ( rst_i                                                        ),
    .evt_i     ( {dma_evt_pulse, llc_write_miss_i, llc_write_hit_i,
                  llc_read_miss_i, llc_read_hit_i}                            ),
    .cnt_clr_i ( cnt_clr                                                      ),
    .cnt_o     ( cnt                                                          )
  );

  dma_evt_rx i_dma_evt_rx (
    .clk_i       ( clk_i              ),
    .rst_i       ( rst_i              ),
    .valid_i     ( dma_pe_evt_valid_i ),
    .ack_o       ( dma_pe_evt_ack_o   ),
    .evt_pulse_o ( dma_evt_pulse      )
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
// Testbench clock and reset source for the host control block
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Released just after the eighth rising edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

// ==== verification/host_ctrl_chk.sv ====
// Concurrent checks on the AXI4-Lite handshake of the LLC configuration port
`timescale 1ns/1ps

module host_ctrl_chk (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              awvalid_i,
  input logic                              awready_i,
  input logic                              wvalid_i,
  input logic                              wready_i,
  input logic                              bvalid_i,
  input logic                              bready_i,
  input logic [1:0]                        bresp_i,
  input logic                              rvalid_i,
  input logic                              rready_i,
  input logic [host_ctrl_pkg::AXIL_DW-1:0] rdata_i
);

  int fail_count = 0;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
  else begin
    $error("bvalid dropped or bresp changed before bready");
    fail_count++;
  end

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
  else begin
    $error("rvalid dropped or rdata changed before rready");
    fail_count++;
  end

  // Write channel ready only against a complete write
  a_wr_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    (awready_i || wready_i) |-> (awvalid_i && wvalid_i))
  else begin
    $error("awready or wready high without both awvalid and wvalid");
    fail_count++;
  end

endmodule

bind host_ctrl_top host_ctrl_chk u_chk (
  .clk_i     ( clk_i            ),
  .rst_i     ( rst_i            ),
  .awvalid_i ( s_axil_awvalid_i ),
  .awready_i ( s_axil_awready_o ),
  .wvalid_i  ( s_axil_wvalid_i  ),
  .wready_i  ( s_axil_wready_o  ),
  .bvalid_i  ( s_axil_bvalid_o  ),
  .bready_i  ( s_axil_bready_i  ),
  .bresp_i   ( s_axil_bresp_o   ),
  .rvalid_i  ( s_axil_rvalid_o  ),
  .rready_i  ( s_axil_rready_i  ),
  .rdata_i   ( s_axil_rdata_o   )
);

// ==== verification/tb_host_ctrl.sv ====
// Directed testbench for the host control block covering config port, windows, counters and DMA events
`timescale 1ns/1ps

module tb_host_ctrl;

  logic clk;
  logic rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [host_ctrl_pkg::AXIL_AW-1:0] awaddr, araddr;
  logic [host_ctrl_pkg::AXIL_DW-1:0] wdata, rdata;
  logic [host_ctrl_pkg::AXIL_SW-1:0] wstrb;
  logic [1:0] bresp, rresp;
  logic [3:0] llc_evt;
  logic dma_valid, dma_ack;
  logic [host_ctrl_pkg::AXIL_DW-1:0] win_out [3];
  // Expected window and counter contents
  logic [host_ctrl_pkg::AXIL_DW-1:0] win_exp [3];
  logic [host_ctrl_pkg::CNT_W-1:0]   cnt_exp [host_ctrl_pkg::NUM_CNT];
  int     max_wait = 100;
  integer seed = 32'h8ed0_baf7;

  tb_clk_gen u_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  host_ctrl_top u_dut (
    .clk_i                  ( clk        ),
    .rst_i                  ( rst        ),
    .s_axil_awvalid_i       ( awvalid    ),
    .s_axil_awready_o       ( awready    ),
    .s_axil_awaddr_i        ( awaddr     ),
    .s_axil_wvalid_i        ( wvalid     ),
    .s_axil_wready_o        ( wready     ),
    .s_axil_wdata_i         ( wdata      ),
    .s_axil_wstrb_i         ( wstrb      ),
    .s_axil_bvalid_o        ( bvalid     ),
    .s_axil_bready_i        ( bready     ),
    .s_axil_bresp_o         ( bresp      ),
    .s_axil_arvalid_i       ( arvalid    ),
    .s_axil_arready_o       ( arready    ),
    .s_axil_araddr_i        ( araddr     ),
    .s_axil_rvalid_o        ( rvalid     ),
    .s_axil_rready_i        ( rready     ),
    .s_axil_rdata_o         ( rdata      ),
    .s_axil_rresp_o         ( rresp      ),
    .llc_read_hit_i         ( llc_evt[0] ),
    .llc_read_miss_i        ( llc_evt[1] ),
    .llc_write_hit_i        ( llc_evt[2] ),
    .llc_write_miss_i       ( llc_evt[3] ),
    .dma_pe_evt_valid_i     ( dma_valid  ),
    .dma_pe_evt_ack_o       ( dma_ack    ),
    .llc_cache_addr_start_o ( win_out[0] ),
    .llc_cache_addr_end_o   ( win_out[1] ),
    .llc_spm_addr_start_o   ( win_out[2] )
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input logic [host_ctrl_pkg::AXIL_DW-1:0] exp,
                            input logic [host_ctrl_pkg::AXIL_DW-1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("Error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
      stop_on_error($sformatf("Error %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic axil_write(input logic [host_ctrl_pkg::AXIL_AW-1:0] addr,
                            input logic [host_ctrl_pkg::AXIL_DW-1:0] data,
                            input logic [host_ctrl_pkg::AXIL_SW-1:0] strb,
                            output logic [1:0] resp);
    int n;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    n = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      n++;
      if (n > max_wait) stop_on_error("Write address and data were never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!(bvalid && bready)) begin
      n++;
      if (n > max_wait) stop_on_error("Write response never completed");
      @(negedge clk);
    end
    resp = bresp;
    @(posedge clk);
    #1;
  endtask

  task automatic axil_read(input logic [host_ctrl_pkg::AXIL_AW-1:0] addr,
                           output logic [host_ctrl_pkg::AXIL_DW-1:0] data,
                           output logic [1:0] resp);
    int n;
    arvalid = 1'b1;
    araddr  = addr;
    n = 0;
    @(negedge clk);
    while (!arready) begin
      n++;
      if (n > max_wait) stop_on_error("Read address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!(rvalid && rready)) begin
      n++;
      if (n > max_wait) stop_on_error("Read response never completed");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk);
    #1;
  endtask

  task automatic write_expect(input string name, input logic [host_ctrl_pkg::AXIL_AW-1:0] addr,
                              input logic [host_ctrl_pkg::AXIL_DW-1:0] data,
                              input logic [host_ctrl_pkg::AXIL_SW-1:0] strb,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(addr, data, strb, resp);
    check_resp($sformatf("%s bresp at %h", name, addr), exp_resp, resp);
  endtask

  task automatic read_expect(input string name, input logic [host_ctrl_pkg::AXIL_AW-1:0] addr,
                             input logic [host_ctrl_pkg::AXIL_DW-1:0] exp);
    logic [host_ctrl_pkg::AXIL_DW-1:0] data;
    logic [1:0] resp;
    axil_read(addr, data, resp);
    check_resp($sformatf("%s rresp at %h", name, addr), host_ctrl_pkg::RESP_OKAY, resp);
    check_data($sformatf("%s rdata at %h", name, addr), exp, data);
  endtask

  // Every mapped register and window output against the model
  task automatic check_registers(input string name);
    for (int i = 0; i < 3; i++) begin
      read_expect(name, 4 * i, win_exp[i]);
      check_data($sformatf("%s window output %0d", name, i), win_exp[i], win_out[i]);
    end
    for (int c = 0; c < host_ctrl_pkg::NUM_CNT; c++)
      read_expect(name, 32'h10 + 4 * c, cnt_exp[c]);
  endtask

  task automatic test_reset_values();
    check_registers("reset_values");
  endtask

  task automatic test_windows();
    logic [host_ctrl_pkg::AXIL_DW-1:0] data;
    logic [host_ctrl_pkg::AXIL_SW-1:0] mask;
    for (int i = 0; i < 3; i++) begin
      data = $random(seed);
      win_exp[i] = data;
      write_expect("windows_full", 4 * i, data, '1, host_ctrl_pkg::RESP_OKAY);
      check_registers("windows_full");
      mask = $random(seed);
      data = $random(seed);
      for (int b = 0; b < host_ctrl_pkg::AXIL_SW; b++)
        if (mask[b]) win_exp[i][8*b +: 8] = data[8*b +: 8];
      write_expect("windows_masked", 4 * i, data, mask, host_ctrl_pkg::RESP_OKAY);
      check_registers("windows_masked");
    end
  endtask

  task automatic test_unmapped();
    logic [host_ctrl_pkg::AXIL_DW-1:0] data;
    logic [1:0] resp;
    for (int a = 'h0c; a < 'h100; a += 4) begin
      if (a > 'h0c && a < 'h24) continue;
      write_expect("unmapped", a, '1, '1, host_ctrl_pkg::RESP_SLVERR);
      axil_read(a, data, resp);
      check_resp($sformatf("unmapped rresp at %h", a), host_ctrl_pkg::RESP_SLVERR, resp);
      check_data($sformatf("unmapped rdata at %h", a), 32'hdeadf000, data);
    end
    check_registers("unmapped");
  endtask

  task automatic test_llc_counters();
    int n;
    for (int c = 0; c < 4; c++) begin
      n = ($random(seed) & 15) + 1;
      llc_evt[c] = 1'b1;
      repeat (n) @(posedge clk);
      #1;
      llc_evt[c] = 1'b0;
      cnt_exp[c] = n;
      check_registers("llc_counters");
    end
    // Cleared one by one while later counters still hold counts
    for (int c = 0; c < 4; c++) begin
      // Any data and strobes clear
      write_expect("llc_counters", 32'h10 + 4 * c, $random(seed), $random(seed),
                   host_ctrl_pkg::RESP_OKAY);
      cnt_exp[c] = '0;
      check_registers("llc_counters_clear");
    end
  endtask

  task automatic test_dma_events();
    int k;
    int n;
    k = ($random(seed) & 7) + 2;
    for (int e = 0; e < k; e++) begin
      dma_valid = ~dma_valid;
      n = 0;
      @(negedge clk);
      while (dma_ack !== dma_valid) begin
        n++;
        if (n > max_wait) stop_on_error("DMA acknowledge never followed the event toggle");
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    cnt_exp[host_ctrl_pkg::CNT_DMA] = k;
    check_registers("dma_events");
  endtask

  task automatic test_back_pressure();
    logic [host_ctrl_pkg::AXIL_DW-1:0] data;
    logic [host_ctrl_pkg::AXIL_DW-1:0] rd_data;
    logic [1:0] wr_resp;
    logic [1:0] rd_resp;
    int n;
    data = $random(seed);
    win_exp[2] = data;
    bready = 1'b0;
    rready = 1'b0;
    fork
      axil_write(32'h08, data, '1, wr_resp);
      axil_read(32'h08, rd_data, rd_resp);
      begin
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
          n++;
          if (n > max_wait) stop_on_error("Write response never appeared under back-pressure");
          @(negedge clk);
        end
        repeat (4) begin
          if (!bvalid || bresp !== host_ctrl_pkg::RESP_OKAY)
            stop_on_error("Write response dropped or changed while bready was low");
          if (arready) stop_on_error("Read accepted while the write response was stalled");
          @(negedge clk);
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
          n++;
          if (n > max_wait) stop_on_error("Read response never appeared under back-pressure");
          @(negedge clk);
        end
        repeat (4) begin
          if (!rvalid || rdata !== data)
            stop_on_error("Read response dropped or changed while rready was low");
          @(negedge clk);
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
      end
    join
    check_resp("back_pressure bresp", host_ctrl_pkg::RESP_OKAY, wr_resp);
    check_resp("back_pressure rresp", host_ctrl_pkg::RESP_OKAY, rd_resp);
    check_data("back_pressure rdata", data, rd_data);
    check_registers("back_pressure");
  endtask

  initial begin
    int n;
    awvalid   = 1'b0;
    wvalid    = 1'b0;
    arvalid   = 1'b0;
    awaddr    = '0;
    araddr    = '0;
    wdata     = '0;
    wstrb     = '0;
    bready    = 1'b1;
    rready    = 1'b1;
    llc_evt   = '0;
    dma_valid = 1'b0;
    for (int i = 0; i < 3; i++) win_exp[i] = '0;
    for (int c = 0; c < host_ctrl_pkg::NUM_CNT; c++) cnt_exp[c] = '0;
    n = 0;
    @(negedge clk);
    while (rst) begin
      n++;
      if (n > max_wait) stop_on_error("Reset was never released");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    test_reset_values();
    test_windows();
    test_unmapped();
    test_llc_counters();
    test_dma_events();
    test_back_pressure();
    if (u_dut.u_chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/host_ctrl_pkg.sv
llc_cfg/llc_cfg_axil_slave.sv
llc_cfg/llc_cfg_regfile.sv
verilog/llc_event_counters.sv
verilog/dma_evt_rx.sv
verilog/host_ctrl_top.sv
verification/tb_clk_gen.sv
verification/host_ctrl_chk.sv
verification/tb_host_ctrl.sv

// ==== Bender.yml ====
package:
  name: host_ctrl

sources:
  - common/host_ctrl_pkg.sv
  - llc_cfg/llc_cfg_axil_slave.sv
  - llc_cfg/llc_cfg_regfile.sv
  - verilog/llc_event_counters.sv
  - verilog/dma_evt_rx.sv
  - verilog/host_ctrl_top.sv
  - target: simulation
    files:
      - verification/tb_clk_gen.sv
      - verification/host_ctrl_chk.sv
      - verification/tb_host_ctrl.sv
